/* hw/dualPortMem.sv */
// Dual-port shared memory top level
// Two port controllers joined to one byte-enable RAM
`timescale 1ns/1ps

module dualPortMem (
   input  logic             clk,
   input  logic             rst,

   // Port A
   input  logic             reqValidA,
   input  memPkg::byteAddrT reqAddrA,
   input  memPkg::strbT     reqStrbA,
   input  memPkg::wordT     reqDataA,
   output logic             rspValidA,
   output logic             rspErrA,
   output memPkg::wordT     rspDataA,

   // Port B
   input  logic             reqValidB,
   input  memPkg::byteAddrT reqAddrB,
   input  memPkg::strbT     reqStrbB,
   input  memPkg::wordT     reqDataB,
   output logic             rspValidB,
   output logic             rspErrB,
   output memPkg::wordT     rspDataB
);

   // RAM ports, one per controller
   memPortIf ifA ();
   memPortIf ifB ();

   memPortCtrl ctrlA (
      .clk      (clk),
      .rst      (rst),
      .reqValid (reqValidA),
      .reqAddr  (reqAddrA),
      .reqStrb  (reqStrbA),
      .reqData  (reqDataA),
      .rspValid (rspValidA),
      .rspErr   (rspErrA),
      .rspData  (rspDataA),
      .mem      (ifA)
   );

   memPortCtrl ctrlB (
      .clk      (clk),
      .rst      (rst),
      .reqValid (reqValidB),
      .reqAddr  (reqAddrB),
      .reqStrb  (reqStrbB),
      .reqData  (reqDataB),
      .rspValid (rspValidB),
      .rspErr   (rspErrB),
      .rspData  (rspDataB),
      .mem      (ifB)
   );

   // Shared storage, no reset on contents
   ramDpBe ram (
      .clk   (clk),
      .portA (ifA),
      .portB (ifB)
   );

endmodule

/* hw/memPkg.sv */
// Shared memory types
// Data word, byte strobe, word address and byte address
`include "mem_consts.svh"

package memPkg;

   // One data word as stored and returned
   typedef logic [`MEM_DATA_W-1:0] wordT;

   // One write enable per byte lane
   typedef logic [`MEM_BYTES-1:0] strbT;

   typedef logic [`MEM_ADDR_W-1:0] addrT;      // Word index into the array
   typedef logic [`MEM_BADDR_W-1:0] byteAddrT; // Address as seen on a port

endpackage

/* hw/memPortCtrl.sv */
// Port controller
// Byte to word address decode, alignment check, response strobes
`timescale 1ns/1ps
`include "mem_consts.svh"

module memPortCtrl (
   input  logic             clk,
   input  logic             rst,

   // Request side
   input  logic             reqValid,
   input  memPkg::byteAddrT reqAddr,
   input  memPkg::strbT     reqStrb,
   input  memPkg::wordT     reqData,

   // Response side
   output logic             rspValid,
   output logic             rspErr,
   output memPkg::wordT     rspData,

   memPortIf.ctrl           mem
);

   // In-word byte offset bits
   localparam int OFFS_W = $clog2(`MEM_BYTES);

   logic aligned;
   logic accept;
   logic reject;

   assign aligned = (reqAddr[OFFS_W-1:0] == '0);
   assign accept  = reqValid && aligned;
   assign reject  = reqValid && !aligned;  // Never reaches the RAM

   // Request goes straight to the RAM port in the same cycle
   assign mem.en   = accept;
   assign mem.we   = reqStrb;  // Zero mask means read
   assign mem.addr = reqAddr[`MEM_BADDR_W-1:OFFS_W];
   assign mem.din  = reqData;

   // Response strobes line up with the RAM output register
   always_ff @(posedge clk) begin
      if (rst) begin
         rspValid <= 1'b0;
         rspErr   <= 1'b0;
      end else begin
         rspValid <= accept;
         rspErr   <= reject;
      end
   end

   // RAM holds dout between accesses, so the old word is valid with rspValid
   assign rspData = mem.dout;

   // One response kind per request
   rspExclusive : assert property (
      @(posedge clk) disable iff (rst) !(rspValid && rspErr)
   ) else $error("memPortCtrl rspValid and rspErr both high");

   // Responses come out of reset quiet
   rspQuietAfterReset : assert property (
      @(posedge clk) rst |=> (!rspValid && !rspErr)
   ) else $error("memPortCtrl response strobe right after reset");

endmodule

/* hw/memPortIf.sv */
// RAM port interface
// Enable, byte write enables, word address and data in both directions
`timescale 1ns/1ps

interface memPortIf;

   logic         en;    // Single-cycle access strobe
   memPkg::strbT we;    // Lanes written on this access
   memPkg::addrT addr;
   memPkg::wordT din;
   memPkg::wordT dout;  // Read-first data, held between accesses

   // Port controller side
   modport ctrl (
      output en,
      output we,
      output addr,
      output din,
      input  dout
   );

   // Storage side
   modport ram (
      input  en,
      input  we,
      input  addr,
      input  din,
      output dout
   );

endinterface

/* hw/mem_consts.svh */
// Memory geometry macros
// Word width, depth, byte lanes and the derived byte address width
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Data word width in bits
`define MEM_DATA_W 32

// Word address width, 256 words deep
`define MEM_ADDR_W 8

// Byte lanes per word
`define MEM_BYTES (`MEM_DATA_W / 8)

// Byte address adds two in-word offset bits
`define MEM_BADDR_W (`MEM_ADDR_W + 2)

`endif

/* hw/ramDp.sv */
// Dual-port read-first RAM for one column
// Registered output per port, single write enable per port
`timescale 1ns/1ps

module ramDp #(
   parameter int ADDR_W = 8,
   parameter int DATA_W = 8
) (
   input  logic              clk,

   // Port A
   input  logic              enA,
   input  logic              weA,
   input  logic [ADDR_W-1:0] addrA,
   input  logic [DATA_W-1:0] dinA,
   output logic [DATA_W-1:0] doutA,

   // Port B
   input  logic              enB,
   input  logic              weB,
   input  logic [ADDR_W-1:0] addrB,
   input  logic [DATA_W-1:0] dinB,
   output logic [DATA_W-1:0] doutB
);

   localparam int DEPTH = 2 ** ADDR_W;

   // Storage array, contents are undefined until written
   logic [DATA_W-1:0] mem [DEPTH];

   // Both ports share one process so the array has a single driver.
   // Nonblocking reads see the word from before this edge on either port,
   // which gives read-first behaviour even across ports.
   always_ff @(posedge clk) begin
      if (enA) begin
         doutA <= mem[addrA];  // Old word out
         if (weA) begin
            mem[addrA] <= dinA;
         end
      end

      if (enB) begin
         doutB <= mem[addrB];
         if (weB) begin
            mem[addrB] <= dinB;  // Same-cell write from A is illegal
         end
      end
   end

   // Outputs hold their value while the port is idle

endmodule

/* hw/ramDpBe.sv */
// Byte-enable dual-port RAM
// One column RAM per byte lane plus a cross-port write collision check
`timescale 1ns/1ps
`include "mem_consts.svh"

module ramDpBe (
   input logic  clk,
   memPortIf.ram portA,
   memPortIf.ram portB
);

   localparam int COL_W = 8;  // Bits per column

   // Lanes that both ports want to write this cycle
   memPkg::strbT overlap;
   logic         sameWord;

   assign overlap  = portA.we & portB.we;
   assign sameWord = portA.en && portB.en && (portA.addr == portB.addr);

   // One column per byte lane
   for (genvar lane = 0; lane < `MEM_BYTES; lane++) begin : laneGen
      ramDp #(
         .ADDR_W (`MEM_ADDR_W),
         .DATA_W (COL_W)
      ) col (
         .clk   (clk),

         .enA   (portA.en),
         .weA   (portA.we[lane]),
         .addrA (portA.addr),
         .dinA  (portA.din[lane*COL_W +: COL_W]),
         .doutA (portA.dout[lane*COL_W +: COL_W]),

         .enB   (portB.en),
         .weB   (portB.we[lane]),
         .addrB (portB.addr),
         .dinB  (portB.din[lane*COL_W +: COL_W]),
         .doutB (portB.dout[lane*COL_W +: COL_W])
      );
   end

   // Both controllers writing one byte in the same cycle has no defined winner
   // Reads alongside a write are fine, read-first on both sides
   writeCollision : assert property (
      @(posedge clk) !(sameWord && (overlap != '0))
   ) else $error("ramDpBe write collision at word %0h lanes %b",
                 portA.addr, overlap);

endmodule

/* list.f */
+incdir+hw
hw/memPkg.sv
hw/memPortIf.sv
hw/ramDp.sv
hw/ramDpBe.sv
hw/memPortCtrl.sv
hw/dualPortMem.sv
tests/tbDualPortMem.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the dual-port memory testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tbDualPortMem

verilator --binary --timing --assert \
   -f list.f \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR" \
   -o simv
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$("./$BUILD_DIR/simv" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation did not report a pass"
   exit 1
fi

/* tests/tbDualPortMem.sv */
// Testbench for the dual-port shared memory
// Word-array reference model, directed test tasks, watchdog and result line
`timescale 1ns/1ps
`include "mem_consts.svh"

module tbDualPortMem;

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 4;
   // Steps per test: reset, full word, byte lanes, read-first, dual port, misaligned
   localparam int TEST_CYCLES = 6 + 17 + 46 + 9 + 49 + 8;
   localparam int MARGIN_CYCLES = 100;

   localparam logic [1:0] KIND_NONE = 2'd0;
   localparam logic [1:0] KIND_RSP  = 2'd1;
   localparam logic [1:0] KIND_ERR  = 2'd2;

   logic clk;
   logic rst;

   logic                    reqValidA, reqValidB;
   logic [`MEM_BADDR_W-1:0] reqAddrA, reqAddrB;
   logic [`MEM_BYTES-1:0]   reqStrbA, reqStrbB;
   logic [`MEM_DATA_W-1:0]  reqDataA, reqDataB;
   logic                    rspValidA, rspValidB;
   logic                    rspErrA, rspErrB;
   logic [`MEM_DATA_W-1:0]  rspDataA, rspDataB;

   // Reference model of the whole array
   logic [`MEM_DATA_W-1:0] model [2**`MEM_ADDR_W];

   // Requests staged for the next cycle, index 0 is port A
   logic                    stValid [2];
   logic [`MEM_BADDR_W-1:0] stAddr [2];
   logic [`MEM_BYTES-1:0]   stStrb [2];
   logic [`MEM_DATA_W-1:0]  stData [2];

   // Expected responses, one cycle behind the requests
   logic [1:0]             nextKind [2];
   logic [`MEM_DATA_W-1:0] nextData [2];
   logic [1:0]             pendKind [2];
   logic [`MEM_DATA_W-1:0] pendData [2];

   integer seed = 26;
   int     errors = 0;
   int     checks = 0;

   dualPortMem dut_i (
      .clk       (clk),
      .rst       (rst),
      .reqValidA (reqValidA),
      .reqAddrA  (reqAddrA),
      .reqStrbA  (reqStrbA),
      .reqDataA  (reqDataA),
      .rspValidA (rspValidA),
      .rspErrA   (rspErrA),
      .rspDataA  (rspDataA),
      .reqValidB (reqValidB),
      .reqAddrB  (reqAddrB),
      .reqStrbB  (reqStrbB),
      .reqDataB  (reqDataB),
      .rspValidB (rspValidB),
      .rspErrB   (rspErrB),
      .rspDataB  (rspDataB)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [`MEM_DATA_W-1:0] randomWord();
      randomWord = $random(seed);
   endfunction

   // Enabled lanes take the new byte, others keep the old one
   function automatic logic [`MEM_DATA_W-1:0] mergeBytes(
      input logic [`MEM_DATA_W-1:0] old,
      input logic [`MEM_DATA_W-1:0] data,
      input logic [`MEM_BYTES-1:0]  strb
   );
      logic [`MEM_DATA_W-1:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      mergeBytes = (old & ~mask) | (data & mask);
   endfunction

   task automatic reportWord(input string name, input logic [`MEM_DATA_W-1:0] expVal,
                             input logic [`MEM_DATA_W-1:0] actVal);
      $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expVal, actVal);
      errors++;
   endtask

   task automatic reportFlag(input string name, input logic expVal, input logic actVal);
      $display("Error at %0t ns: %s expected %b, actual %b", $time, name, expVal, actVal);
      errors++;
   endtask

   task automatic request(input logic sel, input logic [`MEM_BADDR_W-1:0] addr,
                          input logic [`MEM_BYTES-1:0] strb,
                          input logic [`MEM_DATA_W-1:0] data);
      stValid[sel] = 1'b1;
      stAddr[sel]  = addr;
      stStrb[sel]  = strb;
      stData[sel]  = data;
   endtask

   task automatic expectPort(input logic sel);
      logic [`MEM_ADDR_W-1:0] wa;
      wa = stAddr[sel][`MEM_BADDR_W-1:2];
      nextKind[sel] = KIND_NONE;
      nextData[sel] = '0;
      if (stValid[sel]) begin
         if (stAddr[sel][1:0] != 2'b00) begin
            nextKind[sel] = KIND_ERR;  // Misaligned, memory untouched
         end else begin
            nextKind[sel] = KIND_RSP;
            nextData[sel] = model[wa];  // Word before this cycle's writes
         end
      end
   endtask

   task automatic applyWrite(input logic sel);
      logic [`MEM_ADDR_W-1:0] wa;
      wa = stAddr[sel][`MEM_BADDR_W-1:2];
      if (stValid[sel] && stAddr[sel][1:0] == 2'b00 && stStrb[sel] != '0) begin
         model[wa] = mergeBytes(model[wa], stData[sel], stStrb[sel]);
      end
   endtask

   task automatic checkPort(input logic sel);
      logic                   valid;
      logic                   err;
      logic [`MEM_DATA_W-1:0] data;
      logic                   expValid;
      logic                   expErr;
      string                  tag;
      valid    = sel ? rspValidB : rspValidA;
      err      = sel ? rspErrB : rspErrA;
      data     = sel ? rspDataB : rspDataA;
      tag      = sel ? "B" : "A";
      expValid = (pendKind[sel] == KIND_RSP);
      expErr   = (pendKind[sel] == KIND_ERR);
      checks++;
      if (valid !== expValid) reportFlag({"rspValid", tag}, expValid, valid);
      if (err !== expErr) reportFlag({"rspErr", tag}, expErr, err);
      if (expValid && data !== pendData[sel]) reportWord({"rspData", tag}, pendData[sel], data);
   endtask

   // One clock cycle: drive staged requests, check last cycle's responses
   task automatic step();
      expectPort(1'b0);
      expectPort(1'b1);
      applyWrite(1'b0);  // Both reads above already saw the old words
      applyWrite(1'b1);
      @(posedge clk);
      reqValidA <= stValid[0];
      reqAddrA  <= stAddr[0];
      reqStrbA  <= stStrb[0];
      reqDataA  <= stData[0];
      reqValidB <= stValid[1];
      reqAddrB  <= stAddr[1];
      reqStrbB  <= stStrb[1];
      reqDataB  <= stData[1];
      stValid[0] = 1'b0;
      stValid[1] = 1'b0;
      @(negedge clk);
      checkPort(1'b0);
      checkPort(1'b1);
      pendKind[0] = nextKind[0];
      pendKind[1] = nextKind[1];
      pendData[0] = nextData[0];
      pendData[1] = nextData[1];
   endtask

   task automatic testReset();
      repeat (6) step();  // Strobes must stay low while idle
   endtask

   task automatic testFullWord();
      for (int i = 0; i < 8; i++) begin
         request(1'b0, {8'h10 + i[7:0], 2'b00}, 4'hF, randomWord());
         step();
      end
      for (int i = 0; i < 8; i++) begin
         request(1'b1, {8'h10 + i[7:0], 2'b00}, 4'h0, '0);
         step();
      end
      step();
   endtask

   task automatic testByteLanes();
      logic [`MEM_ADDR_W-1:0] wa;
      for (int s = 1; s < 16; s++) begin
         wa = 8'h40 + s[7:0];
         request(1'b0, {wa, 2'b00}, 4'hF, randomWord());   // Known base word
         step();
         request(1'b0, {wa, 2'b00}, s[3:0], randomWord());
         step();
         request(1'b1, {wa, 2'b00}, 4'h0, '0);
         step();
      end
      step();
   endtask

   task automatic testReadFirst();
      logic [`MEM_ADDR_W-1:0] wa;
      for (int i = 0; i < 4; i++) begin
         wa = 8'h60 + i[7:0];
         request(1'b0, {wa, 2'b00}, 4'hF, randomWord());
         step();
         request(1'b0, {wa, 2'b00}, 4'hF, randomWord());  // Returns the first word
         step();
      end
      step();
   endtask

   task automatic testDualPort();
      logic [`MEM_DATA_W-1:0] rndA;
      logic [`MEM_DATA_W-1:0] rndB;
      // Fill both regions first, A owns 0x80 to 0x8F and B owns 0x90 to 0x9F
      for (int i = 0; i < 16; i++) begin
         request(1'b0, {8'h80 + i[7:0], 2'b00}, 4'hF, randomWord());
         request(1'b1, {8'h90 + i[7:0], 2'b00}, 4'hF, randomWord());
         step();
      end
      for (int i = 0; i < 32; i++) begin
         rndA = randomWord();
         rndB = randomWord();
         request(1'b0, {4'h8, rndA[3:0], 2'b00}, rndA[7:4], randomWord());
         request(1'b1, {4'h9, rndB[3:0], 2'b00}, rndB[7:4], randomWord());
         step();
      end
      step();
   endtask

   task automatic testMisaligned();
      logic [`MEM_ADDR_W-1:0] wa;
      wa = 8'hA0;
      request(1'b0, {wa, 2'b00}, 4'hF, randomWord());
      step();
      for (int off = 1; off < 4; off++) begin
         request(1'b0, {wa, off[1:0]}, 4'hF, randomWord());
         step();
         request(1'b1, {wa, 2'b00}, 4'h0, '0);  // Word must be unchanged
         step();
      end
      step();
   endtask

   // Ends a run that does not finish in time
   initial begin
      #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Error: watchdog timeout, the tests did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      reqValidA = 1'b0;
      reqAddrA  = '0;
      reqStrbA  = '0;
      reqDataA  = '0;
      reqValidB = 1'b0;
      reqAddrB  = '0;
      reqStrbB  = '0;
      reqDataB  = '0;
      for (int p = 0; p < 2; p++) begin
         stValid[p]  = 1'b0;
         stAddr[p]   = '0;
         stStrb[p]   = '0;
         stData[p]   = '0;
         pendKind[p] = KIND_NONE;
         pendData[p] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      testReset();
      testFullWord();
      testByteLanes();
      testReadFirst();
      testDualPort();
      testMisaligned();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
